// File: l2_refill_pkg.sv
// line geometry and shared types for the L2 refill path
// offset_width is fixed here because the line types depend on it
package l2_refill_pkg;

    // log2 of 32-bit words per line
    localparam int offset_width = 2;
    localparam int line_words = 1 << offset_width;
    // line address, byte address without the line offset
    localparam int addr_width = 26;

    typedef logic [addr_width-1:0] line_addr_t;
    typedef logic [line_words*32-1:0] line_data_t;

    // one dirty line, cache to write buffer and write buffer to memory
    typedef struct packed {
        line_addr_t addr;
        line_data_t data;
    } evict_t;

    // refill arbiter states
    typedef enum logic [2:0] {
        idle,
        wrt_ar,
        wrt_r,
        ret_ar,
        ret_r
    } arb_state_t;

endpackage

// File: write_buffer.sv
// circular queue of evicted dirty lines; wb_depth must be a power of two, at least 2
// a line answers queries until memory acknowledges its write
`timescale 1ns/1ps

module write_buffer
    import l2_refill_pkg::*;
#(
    parameter int wb_depth = 4
) (
    input  logic       clk,
    input  logic       rstn,
    // eviction side
    input  logic       evict_valid,
    input  evict_t     evict,
    output logic       wb_full,
    // arbiter query
    input  line_addr_t rd_addr,
    output logic       query_ok,
    output line_data_t query_data,
    // memory write side
    output logic       mem_wr_valid,
    output evict_t     mem_wr,
    input  logic       mem_wr_ok
);

    localparam int ptr_width = $clog2(wb_depth);

    evict_t               ent [wb_depth];
    logic [wb_depth-1:0]  valid;
    logic [ptr_width-1:0] head;
    logic [ptr_width-1:0] tail;
    logic                 release_head;
    logic                 merge;
    logic [ptr_width-1:0] merge_idx;

    // entries stay contiguous from head to tail
    assign wb_full      = &valid;
    assign mem_wr_valid = valid[head];
    assign mem_wr       = ent[head];
    assign release_head = valid[head] && mem_wr_ok;

    // look for an entry that already holds the evicted line
    always_comb begin
        merge     = 1'b0;
        merge_idx = '0;
        for (int i = 0; i < wb_depth; i++) begin
            if (valid[i] && ent[i].addr == evict.addr) begin
                merge     = 1'b1;
                merge_idx = ptr_width'(i);
            end
        end
        // head leaves this cycle, so the new data needs its own entry
        if (release_head && merge_idx == head) begin
            merge = 1'b0;
        end
    end

    // associative lookup for the arbiter
    always_comb begin
        query_ok   = 1'b0;
        query_data = '0;
        for (int i = 0; i < wb_depth; i++) begin
            if (valid[i] && ent[i].addr == rd_addr) begin
                query_ok   = 1'b1;
                query_data = ent[i].data;
            end
        end
        // incoming eviction is the newest copy
        if (evict_valid && evict.addr == rd_addr) begin
            query_ok   = 1'b1;
            query_data = evict.data;
        end
    end

    // queue pointers and valid bits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end else begin
            if (release_head) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            if (evict_valid && !merge) begin
                valid[tail] <= 1'b1;
                tail        <= tail + 1'b1;
            end
        end
    end

    // line storage
    always_ff @(posedge clk) begin
        if (evict_valid) begin
            if (merge) begin
                ent[merge_idx].data <= evict.data;
            end else begin
                ent[tail] <= evict;
            end
        end
    end

endmodule

// File: wrt_ret_arbiter.sv
// serves a refill from the write buffer on a hit, else from the return buffer
// one request at a time; rd_req must stay up until addr_ok
`timescale 1ns/1ps

module wrt_ret_arbiter
    import l2_refill_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    // L2 cache side
    input  logic       l2cache_mem_req_r,
    output logic       mem_l2cache_addrOK_r,
    input  logic       l2cache_mem_rdy,
    output logic       mem_l2cache_dataOK,
    output line_data_t din_mem_l2cache,
    // write buffer lookup
    input  line_data_t query_data,
    input  logic       query_ok,
    // return buffer
    output logic       arbiter_mem_req,
    input  logic       mem_arbiter_addrOK,
    input  logic       mem_arbiter_dataOK,
    input  line_data_t dout_mem_arbiter,
    output logic       cache_mem_rdy
);

    arb_state_t state;
    arb_state_t state_nxt;
    line_data_t hold_data;

    assign cache_mem_rdy = l2cache_mem_rdy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (l2cache_mem_req_r) begin
                    state_nxt = query_ok ? wrt_ar : ret_ar;
                end
            end
            wrt_ar: state_nxt = wrt_r;
            wrt_r: begin
                if (l2cache_mem_rdy) begin
                    state_nxt = idle;
                end
            end
            ret_ar: begin
                if (mem_arbiter_addrOK) begin
                    state_nxt = ret_r;
                end
            end
            ret_r: begin
                if (l2cache_mem_rdy && mem_arbiter_dataOK) begin
                    state_nxt = idle;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    // strobes and data toward the cache
    always_comb begin
        mem_l2cache_addrOK_r = 1'b0;
        mem_l2cache_dataOK   = 1'b0;
        arbiter_mem_req      = 1'b0;
        din_mem_l2cache      = '0;
        case (state)
            wrt_ar: mem_l2cache_addrOK_r = 1'b1;
            wrt_r: begin
                mem_l2cache_dataOK = 1'b1;
                din_mem_l2cache    = hold_data;
            end
            ret_ar: begin
                arbiter_mem_req      = 1'b1;
                mem_l2cache_addrOK_r = mem_arbiter_addrOK;
            end
            ret_r: begin
                mem_l2cache_dataOK = mem_arbiter_dataOK;
                din_mem_l2cache    = dout_mem_arbiter;
            end
            default: ;
        endcase
    end

    // snapshot of the hit line, taken when the request is seen
    always_ff @(posedge clk) begin
        if (state == idle && l2cache_mem_req_r && query_ok) begin
            hold_data <= query_data;
        end
    end

endmodule

// File: return_buffer.sv
// fetches one line from memory per arbiter request and keeps it until the cache takes it
// memory must not return data in the cycle of its address acknowledge
`timescale 1ns/1ps

module return_buffer
    import l2_refill_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    // arbiter side
    input  logic       arbiter_mem_req,
    input  line_addr_t rd_addr,
    input  logic       cache_mem_rdy,
    output logic       ret_addr_ok,
    output logic       ret_data_ok,
    output line_data_t ret_data,
    // memory read side
    output logic       mem_rd_req,
    output line_addr_t mem_rd_addr,
    input  logic       mem_rd_addr_ok,
    input  logic       mem_rd_data_ok,
    input  line_data_t mem_rd_data
);

    typedef enum logic [1:0] {
        wait_addr,
        wait_data,
        hold
    } rb_state_t;

    rb_state_t  state;
    rb_state_t  state_nxt;
    line_data_t line_q;

    // cache keeps rd_addr steady until addr_ok
    assign mem_rd_req  = (state == wait_addr) && arbiter_mem_req;
    assign mem_rd_addr = rd_addr;
    assign ret_addr_ok = mem_rd_req && mem_rd_addr_ok;
    assign ret_data_ok = (state == hold);
    assign ret_data    = line_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= wait_addr;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            wait_addr: begin
                if (ret_addr_ok) begin
                    state_nxt = wait_data;
                end
            end
            wait_data: begin
                if (mem_rd_data_ok) begin
                    state_nxt = hold;
                end
            end
            hold: begin
                if (cache_mem_rdy) begin
                    state_nxt = wait_addr;
                end
            end
            default: state_nxt = wait_addr;
        endcase
    end

    // returned line, valid from the next cycle
    always_ff @(posedge clk) begin
        if (state == wait_data && mem_rd_data_ok) begin
            line_q <= mem_rd_data;
        end
    end

endmodule

// File: l2_refill_top.sv
// L2 refill path: write buffer, refill arbiter and return buffer
// one outstanding read; the cache must not evict while wb_full is high
`timescale 1ns/1ps

module l2_refill_top
    import l2_refill_pkg::*;
#(
    parameter int wb_depth = 4
) (
    input  logic       clk,
    input  logic       rstn,
    // L2 cache refill
    input  logic       rd_req,
    input  line_addr_t rd_addr,
    output logic       addr_ok,
    output logic       data_ok,
    output line_data_t rd_data,
    input  logic       cache_rdy,
    // L2 cache eviction
    input  logic       evict_valid,
    input  evict_t     evict,
    output logic       wb_full,
    // memory write
    output logic       mem_wr_valid,
    output evict_t     mem_wr,
    input  logic       mem_wr_ok,
    // memory read
    output logic       mem_rd_req,
    output line_addr_t mem_rd_addr,
    input  logic       mem_rd_addr_ok,
    input  logic       mem_rd_data_ok,
    input  line_data_t mem_rd_data
);

    logic       query_ok;
    line_data_t query_data;
    logic       arbiter_mem_req;
    logic       ret_addr_ok;
    logic       ret_data_ok;
    line_data_t ret_data;
    logic       cache_mem_rdy;

    write_buffer #(
        .wb_depth (wb_depth)
    ) i_write_buffer (
        .clk          (clk),
        .rstn         (rstn),
        .evict_valid  (evict_valid),
        .evict        (evict),
        .wb_full      (wb_full),
        .rd_addr      (rd_addr),
        .query_ok     (query_ok),
        .query_data   (query_data),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr       (mem_wr),
        .mem_wr_ok    (mem_wr_ok)
    );

    wrt_ret_arbiter i_wrt_ret_arbiter (
        .clk                  (clk),
        .rstn                 (rstn),
        .l2cache_mem_req_r    (rd_req),
        .mem_l2cache_addrOK_r (addr_ok),
        .l2cache_mem_rdy      (cache_rdy),
        .mem_l2cache_dataOK   (data_ok),
        .din_mem_l2cache      (rd_data),
        .query_data           (query_data),
        .query_ok             (query_ok),
        .arbiter_mem_req      (arbiter_mem_req),
        .mem_arbiter_addrOK   (ret_addr_ok),
        .mem_arbiter_dataOK   (ret_data_ok),
        .dout_mem_arbiter     (ret_data),
        .cache_mem_rdy        (cache_mem_rdy)
    );

    return_buffer i_return_buffer (
        .clk             (clk),
        .rstn            (rstn),
        .arbiter_mem_req (arbiter_mem_req),
        .rd_addr         (rd_addr),
        .cache_mem_rdy   (cache_mem_rdy),
        .ret_addr_ok     (ret_addr_ok),
        .ret_data_ok     (ret_data_ok),
        .ret_data        (ret_data),
        .mem_rd_req      (mem_rd_req),
        .mem_rd_addr     (mem_rd_addr),
        .mem_rd_addr_ok  (mem_rd_addr_ok),
        .mem_rd_data_ok  (mem_rd_data_ok),
        .mem_rd_data     (mem_rd_data)
    );

endmodule

// File: l2_refill_asserts.sv
// protocol checks bound into l2_refill_top
`timescale 1ns/1ps

module l2_refill_asserts
    import l2_refill_pkg::*;
(
    input logic       clk,
    input logic       rstn,
    input logic       addr_ok,
    input logic       data_ok,
    input logic       cache_rdy,
    input logic       wb_full,
    input logic       mem_rd_req,
    input line_addr_t mem_rd_addr,
    input logic       mem_rd_addr_ok,
    input logic       mem_wr_valid,
    input evict_t     mem_wr,
    input logic       mem_wr_ok
);

    logic addr_seen;
    int   fail_cnt = 0;

    // addr_ok given and transfer not yet done
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_seen <= 1'b0;
        end else if (data_ok && cache_rdy) begin
            addr_seen <= 1'b0;
        end else if (addr_ok) begin
            addr_seen <= 1'b1;
        end
    end

    a_reset: assert property (@(posedge clk)
        !rstn |-> !addr_ok && !data_ok && !mem_rd_req && !mem_wr_valid && !wb_full)
        else begin
            fail_cnt++;
            $error("outputs active during reset");
        end
    a_addr_first: assert property (@(posedge clk) disable iff (!rstn)
        data_ok |-> addr_seen)
        else begin
            fail_cnt++;
            $error("data_ok without an earlier addr_ok");
        end
    a_addr_pulse: assert property (@(posedge clk) disable iff (!rstn)
        addr_ok |=> !addr_ok)
        else begin
            fail_cnt++;
            $error("addr_ok longer than one cycle");
        end
    a_rd_hold: assert property (@(posedge clk) disable iff (!rstn)
        (mem_rd_req && !mem_rd_addr_ok) |=> mem_rd_req && $stable(mem_rd_addr))
        else begin
            fail_cnt++;
            $error("mem_rd_req dropped before its acknowledge");
        end
    // data may still be merged into the line being drained
    a_wr_hold: assert property (@(posedge clk) disable iff (!rstn)
        (mem_wr_valid && !mem_wr_ok) |=> mem_wr_valid && $stable(mem_wr.addr))
        else begin
            fail_cnt++;
            $error("mem_wr_valid dropped before its acknowledge");
        end

endmodule

bind l2_refill_top l2_refill_asserts i_l2_refill_asserts (.*);

// File: tb_l2_refill_top.sv
// testbench for the L2 refill path; memory and L2 cache are behavioural models here
// stimulus is sequential, so no eviction overlaps a read of the same line
`timescale 1ns/1ps

module tb_l2_refill_top;
    import l2_refill_pkg::*;

    localparam int wb_depth = 4;
    localparam int max_cycles = 20000;

    logic       clk;
    logic       rstn;
    logic       rd_req;
    line_addr_t rd_addr;
    logic       addr_ok;
    logic       data_ok;
    line_data_t rd_data;
    logic       cache_rdy;
    logic       evict_valid;
    evict_t     evict;
    logic       wb_full;
    logic       mem_wr_valid;
    evict_t     mem_wr;
    logic       mem_wr_ok;
    logic       mem_rd_req;
    line_addr_t mem_rd_addr;
    logic       mem_rd_addr_ok;
    logic       mem_rd_data_ok;
    line_data_t mem_rd_data;

    integer     seed = 32'ha196;
    int         errors = 0;
    int         cycles = 0;
    line_data_t mem [line_addr_t];
    line_data_t shadow [line_addr_t];
    line_addr_t drain_q [$];
    line_addr_t exp_wr_addr = '0;
    int         pending_cnt = 0;
    line_data_t exp_data = '0;
    line_addr_t cur_addr = '0;
    logic       expect_hit = 1'b0;
    logic       hold_wr = 1'b0;
    int         wr_wait = 0;
    int         rd_wait = 0;
    int         rd_phase = 0;
    line_data_t rd_line;

    l2_refill_top #(
        .wb_depth (wb_depth)
    ) i_l2_refill_top (.*);

    always #10 clk = ~clk;

    // memory contents before any write, every word tied to the full line address
    function automatic line_data_t init_line(line_addr_t a);
        line_data_t d;
        for (int i = 0; i < line_words; i++) begin
            d[i*32 +: 32] = {4'(i), 2'b10, a};
        end
        return d;
    endfunction

    function automatic line_data_t expected_line(line_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_line(a);
    endfunction

    // memory model, observes at the edge and drives 2 ns later
    always @(posedge clk) begin
        logic wr_ok_n;
        logic addr_ok_n;
        logic data_ok_n;
        integer r;
        int found;
        wr_ok_n   = 1'b0;
        addr_ok_n = 1'b0;
        data_ok_n = 1'b0;
        if (rstn) begin
            if (mem_wr_ok) begin
                mem[mem_wr.addr] = mem_wr.data;
                void'(drain_q.pop_front());
            end
            if (evict_valid) begin
                found = 0;
                foreach (drain_q[i]) begin
                    if (drain_q[i] == evict.addr) found = 1;
                end
                if (found == 0) drain_q.push_back(evict.addr);
            end
            exp_wr_addr = (drain_q.size() > 0) ? drain_q[0] : '0;
            pending_cnt = drain_q.size();
            if (mem_wr_valid && !mem_wr_ok && !hold_wr) begin
                if (wr_wait == 0) begin
                    wr_ok_n = 1'b1;
                    r = $random(seed);
                    wr_wait = r[1:0];
                end else begin
                    wr_wait--;
                end
            end
            if (rd_phase == 0 && mem_rd_req && !mem_rd_addr_ok) begin
                if (rd_wait == 0) begin
                    addr_ok_n = 1'b1;
                    rd_line = mem.exists(mem_rd_addr) ? mem[mem_rd_addr]
                                                      : init_line(mem_rd_addr);
                    rd_phase = 1;
                    r = $random(seed);
                    rd_wait = r[1:0];
                end else begin
                    rd_wait--;
                end
            end else if (rd_phase == 1 && !mem_rd_addr_ok) begin
                if (rd_wait == 0) begin
                    data_ok_n = 1'b1;
                    rd_phase = 0;
                    r = $random(seed);
                    rd_wait = r[1:0];
                end else begin
                    rd_wait--;
                end
            end
        end
        #2;
        mem_wr_ok      = wr_ok_n;
        mem_rd_addr_ok = addr_ok_n;
        mem_rd_data_ok = data_ok_n;
        mem_rd_data    = data_ok_n ? rd_line : '0;
    end

    // data and ordering checks
    a_rd_data: assert property (@(posedge clk) disable iff (!rstn)
        (data_ok && cache_rdy) |-> rd_data == exp_data)
        else begin
            errors++;
            $display("Error rd_data: expected %h, got %h",
                $sampled(exp_data), $sampled(rd_data));
        end
    a_hit_timing: assert property (@(posedge clk) disable iff (!rstn)
        ($rose(rd_req) && expect_hit) |=> addr_ok ##1 data_ok)
        else begin
            errors++;
            $display("write-buffer hit did not give addr_ok and data_ok on time");
        end
    a_hit_no_mem: assert property (@(posedge clk) disable iff (!rstn)
        expect_hit |-> !mem_rd_req)
        else begin
            errors++;
            $display("memory read issued during a write-buffer hit");
        end
    a_miss_addr: assert property (@(posedge clk) disable iff (!rstn)
        mem_rd_req |-> mem_rd_addr == cur_addr)
        else begin
            errors++;
            $display("Error mem_rd_addr: expected %h, got %h",
                $sampled(cur_addr), $sampled(mem_rd_addr));
        end
    a_stall: assert property (@(posedge clk) disable iff (!rstn)
        (data_ok && !cache_rdy) |=> data_ok && $stable(rd_data))
        else begin
            errors++;
            $display("data_ok or rd_data changed while cache_rdy was low");
        end
    a_drain_order: assert property (@(posedge clk) disable iff (!rstn)
        (mem_wr_valid && mem_wr_ok) |-> mem_wr.addr == exp_wr_addr)
        else begin
            errors++;
            $display("Error mem_wr.addr: expected %h, got %h",
                $sampled(exp_wr_addr), $sampled(mem_wr.addr));
        end
    a_wb_full: assert property (@(posedge clk) disable iff (!rstn)
        wb_full == (pending_cnt == wb_depth))
        else begin
            errors++;
            $display("Error wb_full: expected %h, got %h",
                $sampled(pending_cnt == wb_depth), $sampled(wb_full));
        end

    task automatic evict_line(input line_addr_t a, input line_data_t d);
        while (wb_full) begin
            @(posedge clk);
            #2;
        end
        evict_valid = 1'b1;
        evict       = '{addr: a, data: d};
        shadow[a]   = d;
        @(posedge clk);
        #2;
        evict_valid = 1'b0;
    endtask

    task automatic read_line(input line_addr_t a, input logic hit, input int stall);
        int waited;
        cur_addr   = a;
        exp_data   = expected_line(a);
        expect_hit = hit;
        rd_req     = 1'b1;
        rd_addr    = a;
        cache_rdy  = (stall == 0);
        do @(posedge clk); while (!addr_ok);
        #2;
        rd_req = 1'b0;
        waited = 0;
        forever begin
            @(posedge clk);
            if (data_ok && cache_rdy) break;
            if (data_ok) begin
                waited++;
                if (waited >= stall) begin
                    #2;
                    cache_rdy = 1'b1;
                end
            end
        end
        #2;
        expect_hit = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: refill did not finish");
            $display("test failed");
            $finish;
        end
    end

    initial begin
        integer r;
        int proto_errors;
        clk = 1'b0;
        rstn = 1'b0;
        rd_req = 1'b0;
        rd_addr = '0;
        cache_rdy = 1'b1;
        evict_valid = 1'b0;
        evict = '0;
        mem_wr_ok = 1'b0;
        mem_rd_addr_ok = 1'b0;
        mem_rd_data_ok = 1'b0;
        mem_rd_data = '0;
        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(posedge clk);
        #2;
        // misses on lines never written
        read_line(26'h10, 1'b0, 0);
        read_line(26'h11, 1'b0, 3);
        // hits while memory holds the drain back
        hold_wr = 1'b1;
        evict_line(26'h20, {4{32'hdead_0020}});
        evict_line(26'h21, {4{32'hdead_0021}});
        read_line(26'h20, 1'b1, 3);
        evict_line(26'h20, {4{32'hbeef_0020}});
        read_line(26'h20, 1'b1, 0);
        evict_line(26'h22, {4{32'hdead_0022}});
        evict_line(26'h23, {4{32'hdead_0023}});
        repeat (3) @(posedge clk);
        #2;
        hold_wr = 1'b0;
        while (mem_wr_valid) begin
            @(posedge clk);
            #2;
        end
        read_line(26'h20, 1'b0, 1);
        // random mix over 16 lines
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            if (r[8]) begin
                evict_line(26'h40 + 26'(r[3:0]), {r, ~r, r ^ 32'h5a5a_5a5a, 32'(n)});
            end else begin
                read_line(26'h40 + 26'(r[3:0]), 1'b0, int'(r[5:4]) % 3);
            end
        end
        repeat (10) @(posedge clk);
        proto_errors = i_l2_refill_top.i_l2_refill_asserts.fail_cnt;
        $display("errors: %0d, protocol errors: %0d", errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: all.f
l2_refill_pkg.sv
write_buffer.sv
wrt_ret_arbiter.sv
return_buffer.sv
l2_refill_top.sv
l2_refill_asserts.sv
tb_l2_refill_top.sv

// File: Makefile
# Verilator simulation of the L2 refill path

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_l2_refill_top -o sim_l2_refill
	./obj_dir/sim_l2_refill | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
